/* hdl/dispatch_pkg.sv */
`default_nettype none

package dispatch_pkg;

    localparam int XLEN      = 32;
    localparam int N_ARF     = 32;
    localparam int ROB_DEPTH = 16;
    localparam int ROB_ID_W  = 4;

    // rv32i major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef logic [XLEN-1:0]          reg_data_t;
    typedef logic [XLEN-1:0]          addr_t;
    typedef logic [$clog2(N_ARF)-1:0] arf_id_t;
    typedef logic [ROB_ID_W-1:0]      rob_id_t;
    typedef logic [31:0]              instr_t;
    typedef logic [2:0]               funct3_t;
    typedef logic [1:0]               ls_width_t;   // 00 byte, 01 half, 10 word

    typedef struct packed {
        instr_t instr;
        addr_t  pc;
        logic   is_cond_br;
        logic   br_dir_pred;        // 1 = predicted taken
        addr_t  br_target_pred;
    } ififo_entry_t;

    typedef struct packed {
        logic      valid;           // source exists
        rob_id_t   rob_id;
        logic      ready;
        reg_data_t data;
    } operand_t;

    typedef struct packed {
        operand_t  src1;
        operand_t  src2;
        logic      dst_valid;
        rob_id_t   instr_rob_id;
        reg_data_t imm;
        addr_t     pc;
        funct3_t   funct3;
        logic      is_r_type;
        logic      is_i_type;
        logic      is_u_type;
        logic      is_b_type;
        logic      is_j_type;
        logic      is_sub;
        logic      is_sra_srai;
        logic      is_lui;
        logic      is_jalr;
        logic      br_dir_pred;
        addr_t     br_target_pred;
    } iiq_entry_t;

    typedef struct packed {
        logic      ld_st;           // 0 load, 1 store
        operand_t  base;
        operand_t  st_data;
        reg_data_t imm;
        rob_id_t   instr_rob_id;
        ls_width_t width;
        logic      ld_sign;         // 1 = zero extend (lbu, lhu)
    } lsq_entry_t;

    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        reg_data_t data;
    } wb_t;

    typedef struct packed {
        logic    valid;
        logic    mispred;
        rob_id_t rob_id;
        addr_t   npc;
    } npc_wb_t;

    typedef struct packed {
        logic      rs1_valid;
        logic      rs2_valid;
        logic      rd_valid;
        arf_id_t   rs1;
        arf_id_t   rs2;
        arf_id_t   rd;
        funct3_t   funct3;
        reg_data_t imm;
        logic      is_r_type;
        logic      is_i_type;
        logic      is_s_type;
        logic      is_b_type;
        logic      is_u_type;
        logic      is_j_type;
        logic      is_sub;
        logic      is_sra_srai;
        logic      is_lui;
        logic      is_jalr;
        logic      is_int_instr;
        logic      is_ls_instr;
        ls_width_t ls_width;
        logic      ld_sign;
    } decoded_t;

endpackage

`default_nettype wire

/* hdl/decode.sv */
`timescale 1ns/1ns
`default_nettype none

module decode (
    input  wire dispatch_pkg::instr_t instr,
    output dispatch_pkg::decoded_t    dec
);
    logic [6:0]              opcode;
    logic                    alt;       // funct7 bit 5 selects sub / sra
    dispatch_pkg::reg_data_t imm_i;
    dispatch_pkg::reg_data_t imm_s;
    dispatch_pkg::reg_data_t imm_b;
    dispatch_pkg::reg_data_t imm_u;
    dispatch_pkg::reg_data_t imm_j;

    assign opcode = instr[6:0];
    assign alt    = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec        = '0;
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.rd     = instr[11:7];
        dec.funct3 = instr[14:12];
        case (opcode)
            dispatch_pkg::OPC_LUI, dispatch_pkg::OPC_AUIPC: begin
                dec.rd_valid     = 1'b1;
                dec.is_u_type    = 1'b1;
                dec.is_lui       = (opcode == dispatch_pkg::OPC_LUI);
                dec.is_int_instr = 1'b1;
                dec.imm          = imm_u;
            end
            dispatch_pkg::OPC_JAL: begin
                dec.rd_valid     = 1'b1;
                dec.is_j_type    = 1'b1;
                dec.is_int_instr = 1'b1;
                dec.imm          = imm_j;
            end
            dispatch_pkg::OPC_JALR: begin
                dec.rs1_valid    = 1'b1;
                dec.rd_valid     = 1'b1;
                dec.is_i_type    = 1'b1;
                dec.is_jalr      = 1'b1;
                dec.is_int_instr = 1'b1;
                dec.imm          = imm_i;
            end
            dispatch_pkg::OPC_BRANCH: begin
                dec.rs1_valid    = 1'b1;
                dec.rs2_valid    = 1'b1;
                dec.is_b_type    = 1'b1;    // no destination
                dec.is_int_instr = 1'b1;
                dec.imm          = imm_b;
            end
            dispatch_pkg::OPC_LOAD: begin
                dec.rs1_valid   = 1'b1;
                dec.rd_valid    = 1'b1;
                dec.is_i_type   = 1'b1;
                dec.is_ls_instr = 1'b1;
                dec.imm         = imm_i;
                dec.ls_width    = instr[13:12];
                dec.ld_sign     = instr[14];
            end
            dispatch_pkg::OPC_STORE: begin
                dec.rs1_valid   = 1'b1;
                dec.rs2_valid   = 1'b1;
                dec.is_s_type   = 1'b1;
                dec.is_ls_instr = 1'b1;
                dec.imm         = imm_s;
                dec.ls_width    = instr[13:12];
            end
            dispatch_pkg::OPC_OP_IMM: begin
                dec.rs1_valid    = 1'b1;
                dec.rd_valid     = 1'b1;
                dec.is_i_type    = 1'b1;
                dec.is_int_instr = 1'b1;
                dec.imm          = imm_i;
                dec.is_sra_srai  = (instr[14:12] == 3'b101) && alt;
            end
            dispatch_pkg::OPC_OP: begin
                dec.rs1_valid    = 1'b1;
                dec.rs2_valid    = 1'b1;
                dec.rd_valid     = 1'b1;
                dec.is_r_type    = 1'b1;
                dec.is_int_instr = 1'b1;
                dec.is_sub       = (instr[14:12] == 3'b000) && alt;
                dec.is_sra_srai  = (instr[14:12] == 3'b101) && alt;
            end
            default: ;
        endcase
        if (dec.rd == '0) begin
            dec.rd_valid = 1'b0;        // writes to x0 are dropped, never renamed
        end
    end

endmodule

`default_nettype wire

/* hdl/rename_table.sv */
`timescale 1ns/1ns
`default_nettype none

module rename_table (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire dispatch_pkg::arf_id_t rs1,
    input  wire dispatch_pkg::arf_id_t rs2,
    output logic                       src1_spec,
    output logic                       src2_spec,
    output dispatch_pkg::rob_id_t      src1_tag,
    output dispatch_pkg::rob_id_t      src2_tag,
    input  wire logic                  rename,
    input  wire dispatch_pkg::arf_id_t rename_rd,
    input  wire dispatch_pkg::rob_id_t rename_tag,
    input  wire logic                  retire,
    input  wire dispatch_pkg::arf_id_t retire_rd,
    input  wire dispatch_pkg::rob_id_t retire_tag,
    input  wire logic                  flush
);
    logic [dispatch_pkg::N_ARF-1:0] spec;   // 1 = value lives in the rob
    dispatch_pkg::rob_id_t          tag [dispatch_pkg::N_ARF];

    assign src1_spec = spec[rs1];
    assign src2_spec = spec[rs2];
    assign src1_tag  = tag[rs1];
    assign src2_tag  = tag[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            spec <= '0;
        end else begin
            // only the youngest producer may release the mapping
            if (retire && tag[retire_rd] == retire_tag) begin
                spec[retire_rd] <= 1'b0;
            end
            if (rename && rename_rd != '0) begin
                spec[rename_rd] <= 1'b1;    // overrides a clear of the same register
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename) begin
            tag[rename_rd] <= rename_tag;
        end
    end

endmodule

`default_nettype wire

/* hdl/rob.sv */
`timescale 1ns/1ns
`default_nettype none

module rob (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    alloc,
    input  wire logic                    alloc_rd_valid,
    input  wire dispatch_pkg::arf_id_t   alloc_rd,
    input  wire dispatch_pkg::addr_t     alloc_pc,
    output logic                         full,
    output dispatch_pkg::rob_id_t        alloc_tag,
    input  wire dispatch_pkg::rob_id_t   rd_tag1,
    input  wire dispatch_pkg::rob_id_t   rd_tag2,
    output logic                         rd_done1,
    output logic                         rd_done2,
    output dispatch_pkg::reg_data_t      rd_data1,
    output dispatch_pkg::reg_data_t      rd_data2,
    input  wire dispatch_pkg::wb_t       alu_wb,
    input  wire dispatch_pkg::wb_t       ld_wb,
    input  wire dispatch_pkg::npc_wb_t   alu_npc,
    output logic                         retire,
    output logic                         retire_rd_valid,
    output dispatch_pkg::arf_id_t        retire_rd,
    output dispatch_pkg::rob_id_t        retire_tag,
    output dispatch_pkg::reg_data_t      retire_data,
    output logic                         redirect,
    output dispatch_pkg::addr_t          redirect_pc
);
    dispatch_pkg::rob_id_t              head;
    dispatch_pkg::rob_id_t              tail;
    logic [dispatch_pkg::ROB_ID_W:0]    count;     // 0 .. ROB_DEPTH
    logic [dispatch_pkg::ROB_DEPTH-1:0] done;
    logic [dispatch_pkg::ROB_DEPTH-1:0] mispred;
    logic [dispatch_pkg::ROB_DEPTH-1:0] rd_valid;
    dispatch_pkg::arf_id_t              rd   [dispatch_pkg::ROB_DEPTH];
    dispatch_pkg::reg_data_t            data [dispatch_pkg::ROB_DEPTH];
    dispatch_pkg::addr_t                npc  [dispatch_pkg::ROB_DEPTH];

    assign full      = (count == (dispatch_pkg::ROB_ID_W + 1)'(dispatch_pkg::ROB_DEPTH));
    assign alloc_tag = tail;

    assign rd_done1 = done[rd_tag1];
    assign rd_done2 = done[rd_tag2];
    assign rd_data1 = data[rd_tag1];
    assign rd_data2 = data[rd_tag2];

    // in-order retire from the head
    assign retire          = (count != '0) && done[head];
    assign retire_rd_valid = rd_valid[head];
    assign retire_rd       = rd[head];
    assign retire_tag      = head;
    assign retire_data     = data[head];
    assign redirect        = retire && mispred[head];
    assign redirect_pc     = npc[head];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (redirect) begin
            head  <= head + 1'b1;       // tags keep counting past the branch
            tail  <= head + 1'b1;
            count <= '0;
        end else begin
            if (alloc) tail <= tail + 1'b1;
            if (retire) head <= head + 1'b1;
            count <= count + {{dispatch_pkg::ROB_ID_W{1'b0}}, alloc}
                           - {{dispatch_pkg::ROB_ID_W{1'b0}}, retire};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || redirect) begin
            done <= '0;
        end else begin
            if (alloc) done[tail] <= 1'b0;
            if (alu_wb.valid) done[alu_wb.rob_id] <= 1'b1;
            if (ld_wb.valid) done[ld_wb.rob_id] <= 1'b1;    // stores complete here too
            if (alu_npc.valid) done[alu_npc.rob_id] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_valid[tail] <= alloc_rd_valid;
            rd[tail]       <= alloc_rd;
            mispred[tail]  <= 1'b0;
            npc[tail]      <= alloc_pc + 32'd4; // fall-through until a branch reports
        end
        if (alu_wb.valid) data[alu_wb.rob_id] <= alu_wb.data;
        if (ld_wb.valid) data[ld_wb.rob_id] <= ld_wb.data;
        if (alu_npc.valid) begin
            mispred[alu_npc.rob_id] <= alu_npc.mispred;
            npc[alu_npc.rob_id]     <= alu_npc.npc;
        end
    end

    function automatic logic in_flight(dispatch_pkg::rob_id_t id);
        dispatch_pkg::rob_id_t off;
        off = id - head;
        return {1'b0, off} < count;
    endfunction

    a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
        alloc |-> !full);

    // execution units only answer for instructions still in the buffer
    a_wb_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        (!alu_wb.valid || in_flight(alu_wb.rob_id)) &&
        (!ld_wb.valid || in_flight(ld_wb.rob_id)) &&
        (!alu_npc.valid || in_flight(alu_npc.rob_id)));

endmodule

`default_nettype wire

/* hdl/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire dispatch_pkg::arf_id_t   raddr1,
    input  wire dispatch_pkg::arf_id_t   raddr2,
    output dispatch_pkg::reg_data_t      rdata1,
    output dispatch_pkg::reg_data_t      rdata2,
    input  wire logic                    we,
    input  wire dispatch_pkg::arf_id_t   waddr,
    input  wire dispatch_pkg::reg_data_t wdata
);
    logic [dispatch_pkg::N_ARF-1:0][dispatch_pkg::XLEN-1:0] regs;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero whatever is stored
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* hdl/dispatch.sv */
`timescale 1ns/1ns
`default_nettype none

module dispatch (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       ififo_valid,
    output logic                            ififo_ready,
    input  wire dispatch_pkg::ififo_entry_t ififo_data,
    input  wire logic                       iiq_ready,
    output logic                            iiq_valid,
    output dispatch_pkg::iiq_entry_t        iiq_data,
    input  wire logic                       lsq_ready,
    output logic                            lsq_valid,
    output dispatch_pkg::lsq_entry_t        lsq_data,
    input  wire logic                       iiq_wakeup_valid,
    input  wire dispatch_pkg::rob_id_t      iiq_wakeup_rob_id,
    input  wire dispatch_pkg::wb_t          alu_wb,
    input  wire dispatch_pkg::wb_t          ld_wb,
    input  wire dispatch_pkg::npc_wb_t      alu_npc,
    output logic                            fetch_redirect_valid,
    output dispatch_pkg::addr_t             fetch_redirect_pc
);
    dispatch_pkg::decoded_t  dec;
    logic                    do_dispatch;
    logic                    rob_full;
    dispatch_pkg::rob_id_t   rob_tag;
    logic                    src1_spec, src2_spec;
    dispatch_pkg::rob_id_t   src1_tag, src2_tag;
    logic                    rob_done1, rob_done2;
    dispatch_pkg::reg_data_t rob_data1, rob_data2;
    dispatch_pkg::reg_data_t arf_data1, arf_data2;
    logic                    retire, retire_rd_valid;
    dispatch_pkg::arf_id_t   retire_rd;
    dispatch_pkg::rob_id_t   retire_tag;
    dispatch_pkg::reg_data_t retire_data;
    dispatch_pkg::operand_t  src1_op, src2_op;

    decode u_decode (.instr(ififo_data.instr), .dec(dec));

    assign do_dispatch = ififo_valid && !rob_full && !fetch_redirect_valid
                         && (iiq_ready || !dec.is_int_instr)
                         && (lsq_ready || !dec.is_ls_instr);
    assign ififo_ready = do_dispatch;
    assign iiq_valid   = do_dispatch && dec.is_int_instr;
    assign lsq_valid   = do_dispatch && dec.is_ls_instr;

    rename_table u_rename_table (
        .clk(clk), .rst_n(rst_n),
        .rs1(dec.rs1), .rs2(dec.rs2),
        .src1_spec(src1_spec), .src2_spec(src2_spec),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .rename(do_dispatch && dec.rd_valid), .rename_rd(dec.rd), .rename_tag(rob_tag),
        .retire(retire && retire_rd_valid), .retire_rd(retire_rd), .retire_tag(retire_tag),
        .flush(fetch_redirect_valid)
    );

    rob u_rob (
        .clk(clk), .rst_n(rst_n),
        .alloc(do_dispatch), .alloc_rd_valid(dec.rd_valid), .alloc_rd(dec.rd),
        .alloc_pc(ififo_data.pc), .full(rob_full), .alloc_tag(rob_tag),
        .rd_tag1(src1_tag), .rd_tag2(src2_tag),
        .rd_done1(rob_done1), .rd_done2(rob_done2),
        .rd_data1(rob_data1), .rd_data2(rob_data2),
        .alu_wb(alu_wb), .ld_wb(ld_wb), .alu_npc(alu_npc),
        .retire(retire), .retire_rd_valid(retire_rd_valid), .retire_rd(retire_rd),
        .retire_tag(retire_tag), .retire_data(retire_data),
        .redirect(fetch_redirect_valid), .redirect_pc(fetch_redirect_pc)
    );

    regfile u_regfile (
        .clk(clk), .rst_n(rst_n),
        .raddr1(dec.rs1), .raddr2(dec.rs2), .rdata1(arf_data1), .rdata2(arf_data2),
        .we(retire && retire_rd_valid), .waddr(retire_rd), .wdata(retire_data)
    );

    // bypass only applies while the register points into the rob
    function automatic dispatch_pkg::operand_t resolve(
        input logic                    exists,
        input logic                    spec,
        input dispatch_pkg::rob_id_t   tag,
        input logic                    rob_done,
        input dispatch_pkg::reg_data_t rob_data,
        input dispatch_pkg::reg_data_t arf_data
    );
        dispatch_pkg::operand_t op;
        logic                   wake_hit;
        logic                   alu_hit;
        logic                   ld_hit;
        wake_hit  = spec && iiq_wakeup_valid && (iiq_wakeup_rob_id == tag);
        alu_hit   = spec && alu_wb.valid && (alu_wb.rob_id == tag);
        ld_hit    = spec && ld_wb.valid && (ld_wb.rob_id == tag);
        op.valid  = exists;
        op.rob_id = tag;
        op.ready  = exists && (wake_hit || alu_hit || ld_hit || !spec || rob_done);
        if (!exists) op.data = '0;
        else if (alu_hit) op.data = alu_wb.data;
        else if (ld_hit) op.data = ld_wb.data;
        else if (!spec) op.data = arf_data;
        else op.data = rob_data;
        return op;
    endfunction

    always_comb begin
        src1_op = resolve(dec.rs1_valid, src1_spec, src1_tag, rob_done1, rob_data1, arf_data1);
        src2_op = resolve(dec.rs2_valid, src2_spec, src2_tag, rob_done2, rob_data2, arf_data2);
    end

    assign iiq_data = '{
        src1: src1_op, src2: src2_op, dst_valid: dec.rd_valid, instr_rob_id: rob_tag,
        imm: dec.imm, pc: ififo_data.pc, funct3: dec.funct3,
        is_r_type: dec.is_r_type, is_i_type: dec.is_i_type, is_u_type: dec.is_u_type,
        is_b_type: dec.is_b_type, is_j_type: dec.is_j_type, is_sub: dec.is_sub,
        is_sra_srai: dec.is_sra_srai, is_lui: dec.is_lui, is_jalr: dec.is_jalr,
        br_dir_pred: ififo_data.br_dir_pred, br_target_pred: ififo_data.br_target_pred
    };

    assign lsq_data = '{
        ld_st: dec.is_s_type, base: src1_op, st_data: src2_op, imm: dec.imm,
        instr_rob_id: rob_tag, width: dec.ls_width, ld_sign: dec.ld_sign
    };

    a_one_queue: assert property (@(posedge clk) disable iff (!rst_n)
        !(iiq_valid && lsq_valid));

endmodule

`default_nettype wire

/* tb/dispatch_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dispatch_tb;
    localparam int TIMEOUT = 50;    // cycles allowed per wait

    logic                       clk;
    logic                       rst_n;
    logic                       ififo_valid;
    logic                       ififo_ready;
    dispatch_pkg::ififo_entry_t ififo_data;
    logic                       iiq_ready;
    logic                       iiq_valid;
    dispatch_pkg::iiq_entry_t   iiq_data;
    logic                       lsq_ready;
    logic                       lsq_valid;
    dispatch_pkg::lsq_entry_t   lsq_data;
    logic                       iiq_wakeup_valid;
    dispatch_pkg::rob_id_t      iiq_wakeup_rob_id;
    dispatch_pkg::wb_t          alu_wb;
    dispatch_pkg::wb_t          ld_wb;
    dispatch_pkg::npc_wb_t      alu_npc;
    logic                       fetch_redirect_valid;
    dispatch_pkg::addr_t        fetch_redirect_pc;

    logic [31:0]           lfsr_state;
    dispatch_pkg::rob_id_t exp_id;      // tag the next dispatch should get
    logic [31:0]           x1_val;
    logic [31:0]           x7_val;

    dispatch u_dut (.*);

    always #20 clk = ~clk;

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[30:0], lfsr_bit()};
        return r;
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] enc_beq(input logic [4:0] rs1, input logic [4:0] rs2,
                                            input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic dispatch_pkg::ififo_entry_t make_entry(input logic [31:0] instr);
        dispatch_pkg::ififo_entry_t e;
        e = '0;
        e.instr = instr;
        e.pc = 32'h1000 + {26'd0, exp_id, 2'b00};
        e.br_target_pred = e.pc + 32'd4;    // predicted not taken
        return e;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // present one instruction and wait until the DUT takes it
    task automatic send(input logic [31:0] instr, input logic wake,
                        input dispatch_pkg::rob_id_t wake_id, input dispatch_pkg::wb_t awb);
        int n;
        n = 0;
        @(posedge clk);
        ififo_valid       <= 1'b1;
        ififo_data        <= make_entry(instr);
        iiq_wakeup_valid  <= wake;
        iiq_wakeup_rob_id <= wake_id;
        alu_wb            <= awb;
        @(negedge clk);
        while (!ififo_ready) begin
            n++;
            if (n > TIMEOUT) stop_with_error("timeout: ififo_ready never went high");
            @(negedge clk);
        end
    endtask

    task automatic finish_dispatch();
        @(posedge clk);             // the transfer edge
        ififo_valid      <= 1'b0;
        iiq_wakeup_valid <= 1'b0;
        alu_wb           <= '0;
        exp_id = exp_id + 4'd1;
    endtask

    task automatic complete(input dispatch_pkg::rob_id_t tag, input logic [31:0] data,
                            input logic load);
        dispatch_pkg::wb_t w;
        w.valid  = 1'b1;
        w.rob_id = tag;
        w.data   = data;
        @(posedge clk);
        if (load) ld_wb <= w;
        else alu_wb <= w;
        @(posedge clk);
        ld_wb  <= '0;
        alu_wb <= '0;
    endtask

    task automatic wait_retire(input dispatch_pkg::rob_id_t tag);
        int n;
        n = 0;
        @(negedge clk);
        while (!(u_dut.retire && u_dut.retire_tag == tag)) begin
            n++;
            if (n > TIMEOUT) stop_with_error("timeout: instruction never retired");
            @(negedge clk);
        end
    endtask

    task automatic test_first_dispatch();
        logic [11:0] imm;
        imm = 12'(rand_bits(12));
        x1_val = {{20{imm[11]}}, imm};      // x0 + imm
        @(negedge clk);
        check("ififo_ready", ififo_ready, 1'b0);
        check("iiq_valid", iiq_valid, 1'b0);
        check("lsq_valid", lsq_valid, 1'b0);
        check("fetch_redirect_valid", fetch_redirect_valid, 1'b0);
        send(enc_addi(5'd1, 5'd0, imm), 1'b0, '0, '0);
        check("iiq_valid", iiq_valid, 1'b1);
        check("ififo_ready", ififo_ready, 1'b1);
        check("iiq_data.src1.ready", iiq_data.src1.ready, 1'b1);
        check("iiq_data.src1.data", iiq_data.src1.data, 32'd0);
        check("iiq_data.imm", iiq_data.imm, x1_val);
        check("iiq_data.instr_rob_id", iiq_data.instr_rob_id, 32'd0);
        finish_dispatch();
    endtask

    task automatic test_rename_forward();
        dispatch_pkg::wb_t w;
        send(enc_add(5'd2, 5'd1, 5'd1), 1'b0, '0, '0);
        check("iiq_data.instr_rob_id", iiq_data.instr_rob_id, 32'd1);
        check("iiq_data.src1.rob_id", iiq_data.src1.rob_id, 32'd0);
        check("iiq_data.src2.rob_id", iiq_data.src2.rob_id, 32'd0);
        check("iiq_data.src1.ready", iiq_data.src1.ready, 1'b0);
        check("iiq_data.src2.ready", iiq_data.src2.ready, 1'b0);
        finish_dispatch();
        send(enc_add(5'd2, 5'd1, 5'd1), 1'b1, 4'd0, '0);    // wakeup for the addi
        check("iiq_data.src1.ready", iiq_data.src1.ready, 1'b1);
        check("iiq_data.src2.ready", iiq_data.src2.ready, 1'b1);
        finish_dispatch();
        w.valid  = 1'b1;
        w.rob_id = 4'd0;
        w.data   = x1_val;
        send(enc_add(5'd2, 5'd1, 5'd1), 1'b0, '0, w);       // alu result of the addi
        check("iiq_data.src1.ready", iiq_data.src1.ready, 1'b1);
        check("iiq_data.src1.data", iiq_data.src1.data, x1_val);
        check("iiq_data.src2.data", iiq_data.src2.data, x1_val);
        finish_dispatch();
    endtask

    task automatic test_retire_read();
        wait_retire(4'd0);
        send(enc_add(5'd3, 5'd1, 5'd0), 1'b0, '0, '0);
        check("iiq_data.src1.ready", iiq_data.src1.ready, 1'b1);
        check("iiq_data.src1.data", iiq_data.src1.data, x1_val);
        check("iiq_data.src2.ready", iiq_data.src2.ready, 1'b1);
        check("iiq_data.src2.data", iiq_data.src2.data, 32'd0);
        finish_dispatch();
    endtask

    task automatic test_backpressure();
        logic [11:0]           off;
        dispatch_pkg::rob_id_t ld_id;
        off = 12'(rand_bits(12));
        @(posedge clk);
        iiq_ready   <= 1'b0;
        ififo_valid <= 1'b1;
        ififo_data  <= make_entry(enc_add(5'd9, 5'd1, 5'd1));
        repeat (3) begin
            @(negedge clk);
            check("ififo_ready", ififo_ready, 1'b0);
            check("iiq_valid", iiq_valid, 1'b0);
        end
        // a load still goes while the integer queue is stalled
        ld_id = exp_id;
        send(enc_lw(5'd5, 5'd1, off), 1'b0, '0, '0);
        check("lsq_valid", lsq_valid, 1'b1);
        check("iiq_valid", iiq_valid, 1'b0);
        check("lsq_data.ld_st", lsq_data.ld_st, 1'b0);
        check("lsq_data.base.ready", lsq_data.base.ready, 1'b1);
        check("lsq_data.base.data", lsq_data.base.data, x1_val);
        check("lsq_data.imm", lsq_data.imm, {{20{off[11]}}, off});
        check("lsq_data.width", lsq_data.width, 2'b10);
        check("lsq_data.instr_rob_id", lsq_data.instr_rob_id, ld_id);
        finish_dispatch();
        for (int i = 1; i < ld_id; i++) complete(4'(i), rand_bits(32), 1'b0);
        complete(ld_id, rand_bits(32), 1'b1);
        wait_retire(ld_id);
        @(posedge clk);
        iiq_ready <= 1'b1;
        repeat (16) begin
            send(enc_addi(5'd7, 5'd0, 12'(exp_id)), 1'b0, '0, '0);
            check("iiq_data.instr_rob_id", iiq_data.instr_rob_id, exp_id);
            finish_dispatch();
        end
        @(posedge clk);
        ififo_valid <= 1'b1;
        ififo_data  <= make_entry(enc_addi(5'd7, 5'd0, 12'd99));
        @(negedge clk);
        check("ififo_ready", ififo_ready, 1'b0);   // rob full
        @(posedge clk);
        ififo_valid <= 1'b0;
    endtask

    task automatic test_redirect();
        dispatch_pkg::rob_id_t br_id;
        dispatch_pkg::npc_wb_t r;
        logic [31:0]           npc;
        int                    n;
        // exp_id has wrapped back to the oldest of the sixteen
        for (int i = 0; i < 16; i++) begin
            x7_val = rand_bits(32);
            complete(exp_id + 4'(i), x7_val, 1'b0);
        end
        wait_retire(exp_id + 4'd15);
        br_id = exp_id;
        send(enc_beq(5'd1, 5'd2, 13'd16), 1'b0, '0, '0);
        check("iiq_data.is_b_type", iiq_data.is_b_type, 1'b1);
        check("iiq_data.dst_valid", iiq_data.dst_valid, 1'b0);
        check("iiq_data.imm", iiq_data.imm, 32'd16);
        check("iiq_data.instr_rob_id", iiq_data.instr_rob_id, br_id);
        finish_dispatch();
        send(enc_addi(5'd7, 5'd0, 12'h05a), 1'b0, '0, '0);  // wrong path
        check("iiq_data.dst_valid", iiq_data.dst_valid, 1'b1);
        finish_dispatch();
        npc = rand_bits(30) << 2;
        r.valid   = 1'b1;
        r.mispred = 1'b1;
        r.rob_id  = br_id;
        r.npc     = npc;
        @(posedge clk);
        alu_npc <= r;
        @(posedge clk);
        alu_npc <= '0;
        n = 0;
        @(negedge clk);
        while (!fetch_redirect_valid) begin
            n++;
            if (n > TIMEOUT) stop_with_error("timeout: no fetch redirect after mispredict");
            @(negedge clk);
        end
        check("fetch_redirect_pc", fetch_redirect_pc, npc);
        exp_id = br_id + 4'd1;
        send(enc_add(5'd8, 5'd7, 5'd0), 1'b0, '0, '0);
        check("iiq_data.src1.ready", iiq_data.src1.ready, 1'b1);
        check("iiq_data.src1.data", iiq_data.src1.data, x7_val);
        check("iiq_data.instr_rob_id", iiq_data.instr_rob_id, exp_id);
        finish_dispatch();
    endtask

    initial begin
        clk               = 1'b0;
        lfsr_state        = 32'd81061;
        exp_id            = '0;
        rst_n             = 1'b0;
        ififo_valid       = 1'b0;
        ififo_data        = '0;
        iiq_ready         = 1'b1;
        lsq_ready         = 1'b1;
        iiq_wakeup_valid  = 1'b0;
        iiq_wakeup_rob_id = '0;
        alu_wb            = '0;
        ld_wb             = '0;
        alu_npc           = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_first_dispatch();
        test_rename_forward();
        test_retire_read();
        test_backpressure();
        test_redirect();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hdl/dispatch_pkg.sv
hdl/decode.sv
hdl/rename_table.sv
hdl/rob.sv
hdl/regfile.sv
hdl/dispatch.sv
tb/dispatch_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module dispatch_tb -f sources.f \
    && ./obj_dir/Vdispatch_tb | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
